// File: rtl/vdp_defs.svh
// Raster timing, border limits, display line mapping and address width macros
`ifndef VDP_DEFS_SVH
`define VDP_DEFS_SVH

//////////////////////////////
// Horizontal VGA timing
//////////////////////////////

// Pixel counts per line
`define VDP_H_TOTAL         10'd800
`define VDP_H_ACTIVE        10'd640
`define VDP_H_SYNC_START    10'd656
`define VDP_H_SYNC_END      10'd752

//////////////////////////////
// Vertical VGA timing
//////////////////////////////

// Line counts per frame
`define VDP_V_TOTAL         10'd525
`define VDP_V_ACTIVE        10'd480
`define VDP_V_SYNC_START    10'd490
`define VDP_V_SYNC_END      10'd492

//////////////////////////////
// Border and line mapping
//////////////////////////////

// Column limits in doubled pixels
`define VDP_BORDER_LEFT         9'd32
`define VDP_BORDER_LEFT_MASKED  9'd40
`define VDP_BORDER_RIGHT        9'd288

// Row limits in half lines
`define VDP_BORDER_TOP      9'd24
`define VDP_BORDER_BOTTOM   9'd216

// Half lines past the wrap point fold back by the offset
`define VDP_LINE_WRAP           9'd242
`define VDP_LINE_WRAP_OFFSET    9'd30

`define VDP_ACTIVE_LINES    8'd192

// CPU side address register
`define VDP_ADDR_W          14

`endif

// File: rtl/vdp_regs_pkg.sv
// CPU side types: command codes, register indices and the status byte
package vdp_regs_pkg;

    // Command code from the top two bits of the second control byte
    typedef enum logic [1:0] {
        code_vram_read  = 2'd0,
        code_vram_write = 2'd1,
        code_reg_write  = 2'd2,
        code_cram_write = 2'd3
    } vdp_code_t;

    // Registers with fields in use, other indices are ignored
    typedef enum logic [3:0] {
        reg_mode_0     = 4'd0,
        reg_mode_1     = 4'd1,
        reg_backdrop   = 4'd7,
        reg_line_count = 4'd10
    } vdp_reg_idx_t;

    // Status byte as seen on the control port
    typedef struct packed {
        logic       frame_pend;
        logic       spr_overflow;
        logic       spr_collision;
        logic [4:0] unused;
    } vdp_status_t;

endpackage

// File: rtl/vdp_video_pkg.sv
// Pixel side types: palette index, palette colour entry and output channel
package vdp_video_pkg;

    // Palette address, top bit selects the sprite half
    typedef logic [4:0] pal_idx_t;

    // Two bits per component, blue in the top pair
    typedef struct packed {
        logic [1:0] b;
        logic [1:0] g;
        logic [1:0] r;
    } pal_color_t;

    // One VGA colour channel
    typedef logic [3:0] chan_t;

endpackage

// File: rtl/vdp_port.sv
// CPU port decoder with address latch, register fields, pending flags and irq
`timescale 1ns/1ps
`include "vdp_defs.svh"

module vdp_port
    import vdp_regs_pkg::*;
    import vdp_video_pkg::*;
(
    input  logic              video_clk,
    input  logic              reset,

    // CPU side
    input  logic              io_portsel,
    input  logic [7:0]        io_wrdata,
    input  logic              io_wren,
    input  logic              io_rddone,
    output vdp_status_t       io_rddata,
    output logic              irq,

    // Palette write port
    output logic              cram_wren,
    output pal_idx_t          cram_addr,
    output pal_color_t        cram_wrdata,

    // Register levels for the raster
    output logic [3:0]        backdrop_idx,
    output logic              left_col_blank,
    output logic [7:0]        line_irq_count,

    // Interrupt pulses from the raster
    input  logic              frame_pulse,
    input  logic              line_pulse
);

    logic                    ctrl_write;
    logic                    data_write;
    logic                    ctrl_rddone;

    logic                    second_byte;
    vdp_code_t               code;
    logic [`VDP_ADDR_W-1:0]  addr;

    logic                    line_irq_en;
    logic                    frame_irq_en;
    logic                    frame_pend;
    logic                    line_pend;

    // Portsel 1 is control, 0 is data
    assign ctrl_write  = io_wren && io_portsel;
    assign data_write  = io_wren && !io_portsel;
    assign ctrl_rddone = io_rddone && io_portsel;

    //////////////////////////////
    // Control port and registers
    //////////////////////////////

    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            second_byte    <= 1'b0;
            code           <= code_vram_read;
            addr           <= '0;
            line_irq_en    <= 1'b0;
            frame_irq_en   <= 1'b0;
            left_col_blank <= 1'b0;
            backdrop_idx   <= 4'd0;
            line_irq_count <= 8'd0;
            frame_pend     <= 1'b0;
            line_pend      <= 1'b0;
        end else begin
            if (ctrl_write) begin
                if (!second_byte) begin
                    addr[7:0] <= io_wrdata;
                end else begin
                    code <= vdp_code_t'(io_wrdata[7:6]);
                    addr[`VDP_ADDR_W-1:8] <= io_wrdata[`VDP_ADDR_W-9:0];

                    // Low address byte carries the register value
                    if (vdp_code_t'(io_wrdata[7:6]) == code_reg_write) begin
                        case (vdp_reg_idx_t'(io_wrdata[3:0]))
                            reg_mode_0: begin
                                left_col_blank <= addr[5];
                                line_irq_en    <= addr[4];
                            end
                            reg_mode_1:     frame_irq_en   <= addr[5];
                            reg_backdrop:   backdrop_idx   <= addr[3:0];
                            reg_line_count: line_irq_count <= addr[7:0];
                            default: ;
                        endcase
                    end
                end
                second_byte <= !second_byte;
            end

            // Auto increment after each data write
            if (data_write) begin
                second_byte <= 1'b0;
                addr        <= addr + `VDP_ADDR_W'(1);
            end

            // Status read clears the flags and the byte latch
            if (ctrl_rddone) begin
                second_byte <= 1'b0;
                frame_pend  <= 1'b0;
                line_pend   <= 1'b0;
            end

            // A new pulse wins over a clear on the same edge
            if (frame_pulse) begin
                frame_pend <= 1'b1;
            end
            if (line_pulse) begin
                line_pend <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Palette write and status
    //////////////////////////////

    assign cram_wren   = data_write && (code == code_cram_write);
    assign cram_addr   = addr[4:0];
    assign cram_wrdata = pal_color_t'(io_wrdata[5:0]);

    // No sprites, so overflow and collision stay zero
    assign io_rddata = '{frame_pend: frame_pend, spr_overflow: 1'b0,
                         spr_collision: 1'b0, unused: 5'd0};

    assign irq = (frame_pend && frame_irq_en) || (line_pend && line_irq_en);

endmodule

// File: rtl/vdp_cram.sv
// 32-entry palette memory with CPU write port and registered raster read
`timescale 1ns/1ps

module vdp_cram
    import vdp_video_pkg::*;
(
    input  logic        video_clk,

    // CPU write side
    input  logic        cram_wren,
    input  pal_idx_t    cram_addr,
    input  pal_color_t  cram_wrdata,

    // Raster read side
    input  pal_idx_t    rd_idx,
    output pal_color_t  rd_color
);

    // Lower half for background, upper half for sprites and backdrop
    pal_color_t mem [32];

    always_ff @(posedge video_clk) begin
        if (cram_wren) begin
            mem[cram_addr] <= cram_wrdata;
        end
    end

    // One cycle read latency, matched by the raster delay stage
    always_ff @(posedge video_clk) begin
        rd_color <= mem[rd_idx];
    end

endmodule

// File: rtl/vdp_raster.sv
// VGA raster counters, sync, border, line interrupts and pixel output registers
`timescale 1ns/1ps
`include "vdp_defs.svh"

module vdp_raster
    import vdp_video_pkg::*;
(
    input  logic        video_clk,
    input  logic        reset,

    // Register levels
    input  logic [3:0]  backdrop_idx,
    input  logic        left_col_blank,
    input  logic [7:0]  line_irq_count,

    // Palette read port
    output pal_idx_t    rd_idx,
    input  pal_color_t  rd_color,

    // Interrupt pulses
    output logic        frame_pulse,
    output logic        line_pulse,

    // VGA output
    output chan_t       video_r,
    output chan_t       video_g,
    output chan_t       video_b,
    output logic        video_de,
    output logic        video_hsync,
    output logic        video_vsync,
    output logic        video_newframe
);

    logic [9:0] hcnt;
    logic [9:0] vcnt;
    logic       hlast;
    logic       hblank;
    logic       vblank;
    logic       hsync;
    logic       vsync;
    logic       newframe;

    logic [8:0] hcnt9;
    logic [8:0] vcnt9;
    logic [8:0] next_vcnt9;
    logic       hborder;
    logic       vborder;
    logic       border;
    pal_idx_t   border_idx;
    pal_idx_t   active_idx;

    logic       line_step;
    logic [7:0] disp_line;
    logic [7:0] line_cnt;

    logic       q_hsync;
    logic       q_vsync;
    logic       q_blank;
    logic       q_newframe;

    //////////////////////////////
    // Counters and sync
    //////////////////////////////

    assign hlast = (hcnt == `VDP_H_TOTAL - 10'd1);

    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            hcnt <= 10'd0;
            vcnt <= 10'd0;
        end else if (hlast) begin
            hcnt <= 10'd0;
            vcnt <= (vcnt == `VDP_V_TOTAL - 10'd1) ? 10'd0 : vcnt + 10'd1;
        end else begin
            hcnt <= hcnt + 10'd1;
        end
    end

    assign hblank   = (hcnt >= `VDP_H_ACTIVE);
    assign vblank   = (vcnt >= `VDP_V_ACTIVE);
    assign hsync    = (hcnt >= `VDP_H_SYNC_START) && (hcnt < `VDP_H_SYNC_END);
    assign vsync    = (vcnt >= `VDP_V_SYNC_START) && (vcnt < `VDP_V_SYNC_END);
    assign newframe = (hcnt == 10'd0) && (vcnt == 10'd0);

    //////////////////////////////
    // Border and palette index
    //////////////////////////////

    // Every source pixel and line is shown twice
    assign hcnt9 = hcnt[9:1];
    assign vcnt9 = vcnt[9:1];

    assign hborder = !hblank && ((hcnt9 < (left_col_blank ? `VDP_BORDER_LEFT_MASKED
                                                           : `VDP_BORDER_LEFT))
                                 || (hcnt9 >= `VDP_BORDER_RIGHT));
    assign vborder = !vblank && ((vcnt9 < `VDP_BORDER_TOP) || (vcnt9 >= `VDP_BORDER_BOTTOM));
    assign border  = hborder || vborder;

    // No renderer yet, active area falls back to the backdrop as well
    assign border_idx = {1'b1, backdrop_idx};
    assign active_idx = {1'b1, backdrop_idx};
    assign rd_idx     = border ? border_idx : active_idx;

    //////////////////////////////
    // Line step and interrupts
    //////////////////////////////

    // Half line advances at the end of each odd VGA line
    assign line_step  = hlast && vcnt[0];
    assign next_vcnt9 = vcnt9 + 9'd1;

    // Display line of the half line being entered, modulo 256
    always_comb begin
        disp_line = 8'(next_vcnt9 - `VDP_BORDER_TOP);
        if (next_vcnt9 < `VDP_BORDER_TOP) begin
            disp_line = 8'(next_vcnt9 + (9'd256 - `VDP_BORDER_TOP));
        end
        if (next_vcnt9 > `VDP_LINE_WRAP) begin
            disp_line = 8'(next_vcnt9 - `VDP_LINE_WRAP_OFFSET);
        end
    end

    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            frame_pulse <= 1'b0;
            line_pulse  <= 1'b0;
            line_cnt    <= 8'd0;
        end else begin
            frame_pulse <= line_step && (disp_line == `VDP_ACTIVE_LINES);
            line_pulse  <= 1'b0;
            if (line_step) begin
                if (disp_line <= `VDP_ACTIVE_LINES) begin
                    if (line_cnt == 8'd0) begin
                        line_pulse <= 1'b1;
                        line_cnt   <= line_irq_count;
                    end else begin
                        line_cnt <= line_cnt - 8'd1;
                    end
                end else begin
                    // Outside the display the counter holds the reload value
                    line_cnt <= line_irq_count;
                end
            end
        end
    end

    //////////////////////////////
    // Output pipeline
    //////////////////////////////

    always_ff @(posedge video_clk or posedge reset) begin
        if (reset) begin
            q_hsync        <= 1'b0;
            q_vsync        <= 1'b0;
            q_blank        <= 1'b1;
            q_newframe     <= 1'b0;
            video_hsync    <= 1'b0;
            video_vsync    <= 1'b0;
            video_newframe <= 1'b0;
            video_de       <= 1'b0;
            video_r        <= 4'd0;
            video_g        <= 4'd0;
            video_b        <= 4'd0;
        end else begin
            // Align with the palette read
            q_hsync        <= hsync;
            q_vsync        <= vsync;
            q_blank        <= hblank || vblank;
            q_newframe     <= newframe;

            video_hsync    <= q_hsync;
            video_vsync    <= q_vsync;
            video_newframe <= q_newframe;
            video_de       <= !q_blank;
            if (q_blank) begin
                video_r <= 4'd0;
                video_g <= 4'd0;
                video_b <= 4'd0;
            end else begin
                video_r <= {rd_color.r, rd_color.r};
                video_g <= {rd_color.g, rd_color.g};
                video_b <= {rd_color.b, rd_color.b};
            end
        end
    end

endmodule

// File: rtl/vdp_video.sv
// Video processor top level: port decoder, palette memory and raster
`timescale 1ns/1ps
`include "vdp_defs.svh"

module vdp_video
    import vdp_regs_pkg::*;
    import vdp_video_pkg::*;
(
    input  logic        video_clk,
    input  logic        reset,

    // CPU register port
    input  logic        io_portsel,
    input  logic [7:0]  io_wrdata,
    input  logic        io_wren,
    input  logic        io_rddone,
    output vdp_status_t io_rddata,
    output logic        irq,

    // VGA output
    output chan_t       video_r,
    output chan_t       video_g,
    output chan_t       video_b,
    output logic        video_de,
    output logic        video_hsync,
    output logic        video_vsync,
    output logic        video_newframe
);

    logic       cram_wren;
    pal_idx_t   cram_addr;
    pal_color_t cram_wrdata;
    pal_idx_t   rd_idx;
    pal_color_t rd_color;
    logic [3:0] backdrop_idx;
    logic       left_col_blank;
    logic [7:0] line_irq_count;
    logic       frame_pulse;
    logic       line_pulse;

    vdp_port u_port (
        .video_clk      (video_clk),
        .reset          (reset),
        .io_portsel     (io_portsel),
        .io_wrdata      (io_wrdata),
        .io_wren        (io_wren),
        .io_rddone      (io_rddone),
        .io_rddata      (io_rddata),
        .irq            (irq),
        .cram_wren      (cram_wren),
        .cram_addr      (cram_addr),
        .cram_wrdata    (cram_wrdata),
        .backdrop_idx   (backdrop_idx),
        .left_col_blank (left_col_blank),
        .line_irq_count (line_irq_count),
        .frame_pulse    (frame_pulse),
        .line_pulse     (line_pulse)
    );

    vdp_cram u_cram (
        .video_clk   (video_clk),
        .cram_wren   (cram_wren),
        .cram_addr   (cram_addr),
        .cram_wrdata (cram_wrdata),
        .rd_idx      (rd_idx),
        .rd_color    (rd_color)
    );

    vdp_raster u_raster (
        .video_clk      (video_clk),
        .reset          (reset),
        .backdrop_idx   (backdrop_idx),
        .left_col_blank (left_col_blank),
        .line_irq_count (line_irq_count),
        .rd_idx         (rd_idx),
        .rd_color       (rd_color),
        .frame_pulse    (frame_pulse),
        .line_pulse     (line_pulse),
        .video_r        (video_r),
        .video_g        (video_g),
        .video_b        (video_b),
        .video_de       (video_de),
        .video_hsync    (video_hsync),
        .video_vsync    (video_vsync),
        .video_newframe (video_newframe)
    );

endmodule

// File: tests/tb_vdp_video.sv
// Testbench for the video processor: command file player, compare tasks and watchdog
`timescale 1ns/1ps
`include "vdp_defs.svh"

module tb_vdp_video
    import vdp_regs_pkg::*;
    import vdp_video_pkg::*;
();

    localparam int CLK_HALF     = 20;
    localparam int CLK_PERIOD   = 40;
    localparam int LINE_CYCLES  = int'(`VDP_H_TOTAL);
    localparam int FRAME_CYCLES = int'(`VDP_H_TOTAL) * int'(`VDP_V_TOTAL);

    // Vertical sync on lines 490 and 491, active area 640 by 480
    localparam int VSYNC_START_CYCLE = 490 * LINE_CYCLES;
    localparam int VSYNC_CYCLES      = 2 * LINE_CYCLES;
    localparam int DE_CYCLES         = 640 * 480;

    logic        video_clk;
    logic        reset;
    logic        io_portsel;
    logic [7:0]  io_wrdata;
    logic        io_wren;
    logic        io_rddone;
    vdp_status_t io_rddata;
    logic        irq;
    chan_t       video_r;
    chan_t       video_g;
    chan_t       video_b;
    logic        video_de;
    logic        video_hsync;
    logic        video_vsync;
    logic        video_newframe;

    // Command list from the test file
    logic [7:0]  op_q[$];
    logic [15:0] arg_a_q[$];
    logic [15:0] arg_b_q[$];
    int          frame_sum;
    bit          cmds_loaded;

    int          status_errors;
    int          color_errors;
    int          irq_errors;
    int          timing_errors;
    int          other_errors;

    vdp_video u_vdp_video (
        .video_clk      (video_clk),
        .reset          (reset),
        .io_portsel     (io_portsel),
        .io_wrdata      (io_wrdata),
        .io_wren        (io_wren),
        .io_rddone      (io_rddone),
        .io_rddata      (io_rddata),
        .irq            (irq),
        .video_r        (video_r),
        .video_g        (video_g),
        .video_b        (video_b),
        .video_de       (video_de),
        .video_hsync    (video_hsync),
        .video_vsync    (video_vsync),
        .video_newframe (video_newframe)
    );

    initial begin
        video_clk = 1'b0;
        forever #CLK_HALF video_clk = ~video_clk;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_status(input vdp_status_t got, input vdp_status_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t io_rddata got %h expected %h", $time, got, exp);
            status_errors++;
        end
    endtask

    task automatic check_color(input chan_t exp_r, input chan_t exp_g, input chan_t exp_b,
                               output bit match);
        match = 1'b1;
        if (video_r !== exp_r) begin
            $display("ERROR t=%0t video_r got %h expected %h", $time, video_r, exp_r);
            match = 1'b0;
        end
        if (video_g !== exp_g) begin
            $display("ERROR t=%0t video_g got %h expected %h", $time, video_g, exp_g);
            match = 1'b0;
        end
        if (video_b !== exp_b) begin
            $display("ERROR t=%0t video_b got %h expected %h", $time, video_b, exp_b);
            match = 1'b0;
        end
        if (!match) begin
            color_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
            irq_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            timing_errors++;
        end
    endtask

    //////////////////////////////
    // Command file
    //////////////////////////////

    task automatic load_commands();
        int          fd;
        int          n;
        int          want;
        int          ch;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        fd = $fopen("tests/vdp_video_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file tests/vdp_video_tests.txt");
            other_errors++;
            return;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            a = '0;
            b = '0;
            if (op == "#") begin
                // Skip the rest of a comment line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                case (op)
                    "W", "F", "H": begin
                        want = 2;
                        n    = $fscanf(fd, " %h %h", a, b);
                    end
                    "S", "C": begin
                        want = 1;
                        n    = $fscanf(fd, " %h", a);
                    end
                    default: begin
                        want = 1;
                        n    = 0;
                    end
                endcase
                if (n != want) begin
                    $display("Malformed or unknown command '%c' in the command file", op);
                    other_errors++;
                end else begin
                    op_q.push_back(op);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                    if (op == "F") begin
                        frame_sum += int'(a);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Command players
    //////////////////////////////

    task automatic write_port(input logic port, input logic [7:0] data);
        io_portsel = port;
        io_wrdata  = data;
        io_wren    = 1'b1;
        @(negedge video_clk);
        io_wren    = 1'b0;
    endtask

    task automatic read_status(input vdp_status_t exp);
        check_status(io_rddata, exp);
        io_portsel = 1'b1;
        io_rddone  = 1'b1;
        @(negedge video_clk);
        io_rddone  = 1'b0;
    endtask

    // Returns at the first sample where the chosen output is high after being low
    task automatic wait_rising(input bit sel_hsync, input int limit, output bit found);
        logic prev;
        logic now;
        int   waited;
        waited = 0;
        prev   = sel_hsync ? video_hsync : video_de;
        @(negedge video_clk);
        now = sel_hsync ? video_hsync : video_de;
        while (!(now && !prev) && waited < limit) begin
            prev = now;
            @(negedge video_clk);
            now = sel_hsync ? video_hsync : video_de;
            waited++;
        end
        found = now && !prev;
    endtask

    task automatic sample_line_color(input logic [11:0] rgb);
        bit found;
        bit match;
        wait_rising(1'b0, FRAME_CYCLES, found);
        if (!found) begin
            $display("video_de did not rise within one frame");
            other_errors++;
        end else begin
            // Whole active line from the cycle after the rise
            @(negedge video_clk);
            match = 1'b1;
            while (video_de && match) begin
                check_color(rgb[11:8], rgb[7:4], rgb[3:0], match);
                @(negedge video_clk);
            end
        end
    endtask

    task automatic count_frames_then_irq(input int frames, input logic exp_irq);
        int count;
        int waited;
        count  = 0;
        waited = 0;
        while (count < frames && waited <= (frames + 1) * FRAME_CYCLES) begin
            @(negedge video_clk);
            waited++;
            if (video_newframe) begin
                count++;
            end
        end
        if (count < frames) begin
            $display("Only %0d of %0d video_newframe pulses arrived", count, frames);
            other_errors++;
        end else begin
            check_bit("irq", irq, exp_irq);
        end
    endtask

    task automatic measure_hsync(input int exp_width, input int exp_period);
        bit found;
        bit match;
        int width;
        int period;
        width  = 0;
        period = 0;
        wait_rising(1'b1, 2 * LINE_CYCLES, found);
        if (!found) begin
            $display("video_hsync did not rise within two lines");
            other_errors++;
        end else begin
            while (video_hsync && period < 2 * LINE_CYCLES) begin
                width++;
                period++;
                @(negedge video_clk);
            end
            // Blanked part of the line must carry black
            while (!video_hsync && period < 2 * LINE_CYCLES) begin
                if (!video_de) begin
                    check_color(4'd0, 4'd0, 4'd0, match);
                end
                period++;
                @(negedge video_clk);
            end
            check_count("hsync width", width, exp_width);
            check_count("line period", period, exp_period);
        end
    endtask

    //////////////////////////////
    // Frame timing monitor
    //////////////////////////////

    // Vertical sync and active area measured between video_newframe pulses
    initial begin
        bit   in_frame;
        logic prev_vsync;
        int   cyc;
        int   vsync_start;
        int   vsync_width;
        int   de_cycles;
        in_frame    = 1'b0;
        prev_vsync  = 1'b0;
        cyc         = 0;
        vsync_start = -1;
        vsync_width = 0;
        de_cycles   = 0;
        forever begin
            @(negedge video_clk);
            if (video_newframe) begin
                if (in_frame) begin
                    check_count("vsync start", vsync_start, VSYNC_START_CYCLE);
                    check_count("vsync width", vsync_width, VSYNC_CYCLES);
                    check_count("video_de cycles", de_cycles, DE_CYCLES);
                end
                in_frame    = 1'b1;
                cyc         = 0;
                vsync_start = -1;
                vsync_width = 0;
                de_cycles   = 0;
            end
            if (video_vsync && !prev_vsync && vsync_start < 0) begin
                vsync_start = cyc;
            end
            if (video_vsync) begin
                vsync_width++;
            end
            if (video_de) begin
                de_cycles++;
            end
            prev_vsync = video_vsync;
            cyc++;
        end
    end

    //////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////

    initial begin
        int total;
        reset         = 1'b1;
        io_portsel    = 1'b0;
        io_wrdata     = 8'd0;
        io_wren       = 1'b0;
        io_rddone     = 1'b0;
        frame_sum     = 0;
        cmds_loaded   = 1'b0;
        status_errors = 0;
        color_errors  = 0;
        irq_errors    = 0;
        timing_errors = 0;
        other_errors  = 0;
        load_commands();
        if (op_q.size() == 0) begin
            $display("The command file held no commands");
            other_errors++;
        end
        cmds_loaded = 1'b1;
        repeat (5) @(posedge video_clk);
        @(negedge video_clk);
        reset = 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": write_port(arg_a_q[i][0], arg_b_q[i][7:0]);
                "S": read_status(vdp_status_t'(arg_a_q[i][7:0]));
                "C": sample_line_color(arg_a_q[i][11:0]);
                "F": count_frames_then_irq(int'(arg_a_q[i]), arg_b_q[i][0]);
                "H": measure_hsync(int'(arg_a_q[i]), int'(arg_b_q[i]));
                default: other_errors++;
            endcase
        end
        total = status_errors + color_errors + irq_errors + timing_errors + other_errors;
        $display("Errors: status %0d, color %0d, irq %0d, timing %0d, other %0d",
                 status_errors, color_errors, irq_errors, timing_errors, other_errors);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Limit grows with the frames the command list waits for
    initial begin
        longint limit_ns;
        wait (cmds_loaded);
        limit_ns = longint'(frame_sum + 3) * longint'(FRAME_CYCLES) * longint'(CLK_PERIOD);
        #(limit_ns);
        $display("Watchdog expired after %0d ns before the command list finished", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/vdp_video_tests.txt
# Columns, all hex: W port byte | S status | C rgb (r g b nibbles) | F frames irq
# H hsync_width line_period
# Palette entry 0x15 = 0x2d, backdrop 5
W 1 15
W 1 c0
W 0 2d
W 1 05
W 1 87
C 5fa
# Palette entry 0x1a = 0x36, backdrop 10
W 1 1a
W 1 c0
W 0 36
W 1 0a
W 1 87
C a5f
H 60 320
# Frame interrupt enable, then status clears it
W 1 20
W 1 81
F 1 1
S 80
S 00
F 0 0
# Line interrupt every 5 lines, frame interrupt off
W 1 00
W 1 81
W 1 04
W 1 8a
W 1 10
W 1 80
F 1 1
S 80
F 0 0
# Count 255 never expires within a frame
W 1 ff
W 1 8a
F 1 0
F 1 0
# Stray first byte, status read resets the latch
W 1 3c
S 80
W 1 13
W 1 c0
W 0 0e
W 1 03
W 1 87
C af0

// File: sim.f
+incdir+rtl
rtl/vdp_regs_pkg.sv
rtl/vdp_video_pkg.sv
rtl/vdp_port.sv
rtl/vdp_cram.sv
rtl/vdp_raster.sv
rtl/vdp_video.sv
tests/tb_vdp_video.sv

// File: Makefile
# Verilator simulation of the video processor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_vdp_video
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
